//--- hdl/bpPkg.sv
// Branch direction predictor package with counter states, update rules and defaults
`default_nettype none

package bpPkg;

  //////////////////////////////////////////////////
  // Top level parameter defaults
  //////////////////////////////////////////////////

  // PC width of the core
  parameter int DEF_XLEN = 32;
  // Counter table index width, 1024 entries by default
  parameter int DEF_INDEX_BITS = 10;

  //////////////////////////////////////////////////
  // Two bit saturating counter
  //////////////////////////////////////////////////

  // Four state counter FSM
  // Top bit is the predicted direction
  typedef enum logic [1:0] {
    strongNotTaken = 2'b00,
    weakNotTaken   = 2'b01,
    weakTaken      = 2'b10,
    strongTaken    = 2'b11
  } bpDir_t;

  // Predicted direction carried by a counter
  function automatic logic predTaken(input bpDir_t state);
    return state[1];
  endfunction

  // Next counter state once the branch has resolved
  function automatic bpDir_t satUpdate(input bpDir_t state, input logic taken);
    bpDir_t nextState;
    // One step toward the resolved direction
    // Both ends saturate
    case (state)
      strongNotTaken: nextState = taken ? weakNotTaken : strongNotTaken;
      weakNotTaken:   nextState = taken ? weakTaken    : strongNotTaken;
      weakTaken:      nextState = taken ? strongTaken  : weakNotTaken;
      default:        nextState = taken ? strongTaken  : weakTaken;
    endcase
    return nextState;
  endfunction

endpackage

`default_nettype wire

//--- hdl/pipeCtrlIf.sv
// Per-stage stall and flush bundle from the hazard unit to the direction predictor
`timescale 1ns/1ns
`default_nettype none

interface pipeCtrlIf;

  // Hold requests, one per pipeline register
  logic stallF;
  logic stallD;
  logic stallE;
  logic stallM;
  logic stallW;

  // Clear requests
  // Fetch has none, its register is the table read port
  logic flushD;
  logic flushE;
  logic flushM;
  logic flushW;

  // Hazard unit side drives every control
  modport ctrl (
    output stallF, stallD, stallE, stallM, stallW,
    output flushD, flushE, flushM, flushW
  );

  // Predictor side only observes
  modport pred (
    input stallF, stallD, stallE, stallM, stallW,
    input flushD, flushE, flushM, flushW
  );

endinterface

`default_nettype wire

//--- hdl/bhtRam.sv
// Branch history table, one registered read port and one write port of 2-bit counters
`timescale 1ns/1ns
`default_nettype none

module bhtRam import bpPkg::*; #(
  parameter int addrBits = DEF_INDEX_BITS
) (
  input  wire logic                clk,
  input  wire logic                arstN,
  // Read port, Fetch side
  input  wire logic                readEn,
  input  wire logic [addrBits-1:0] readAddr,
  output      bpDir_t              readData,
  // Write port, Writeback side
  input  wire logic                writeEn,
  input  wire logic [addrBits-1:0] writeAddr,
  input  wire bpDir_t              writeData
);

  // One counter per table entry
  localparam int depth = 2 ** addrBits;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  // Counter array
  // Contents are undefined until an entry is written
  bpDir_t mem [0:depth-1];

  // Synchronous write
  always_ff @(posedge clk) begin
    if (writeEn) begin
      mem[writeAddr] <= writeData;
    end
  end

  //////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////

  // Registered read, holds while the enable is low
  // Same-address write in this cycle returns the old entry
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      readData <= strongNotTaken;
    end else if (readEn) begin
      readData <= mem[readAddr];
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Every write must land on a known entry with a known counter
  // A bad value here would corrupt the table for good
  writeKnown: assert property (
    @(posedge clk) disable iff (!arstN)
    writeEn |-> !$isunknown({writeAddr, writeData})
  ) else $error("bhtRam write with unknown address or data");

  // Read port must not load on an unknown enable
  // Otherwise readData goes unknown for the rest of the run
  readEnKnown: assert property (
    @(posedge clk) disable iff (!arstN)
    !$isunknown(readEn)
  ) else $error("bhtRam read enable is unknown");

endmodule

`default_nettype wire

//--- hdl/twoBitPredictor.sv
// Two-bit saturating counter direction predictor with PC hash and stage registers
`timescale 1ns/1ns
`default_nettype none

module twoBitPredictor import bpPkg::*; #(
  parameter int xlen      = DEF_XLEN,
  parameter int indexBits = DEF_INDEX_BITS
) (
  input  wire logic            clk,
  input  wire logic            arstN,
  // Per-stage stall and flush from the hazard unit
  pipeCtrlIf.pred              ctrl,
  // Fetch address for the next instruction
  input  wire logic [xlen-1:0] pcNextF,
  // Address of the instruction now in Memory
  input  wire logic [xlen-1:0] pcM,
  input  wire logic            branchE,
  input  wire logic            branchM,
  // Resolved direction in Execute
  input  wire logic            pcSrcE,
  output      bpDir_t          bpDirF,
  output      logic            bpDirWrongE
);

  typedef logic [xlen-1:0]      pc_t;
  typedef logic [indexBits-1:0] index_t;

  // Table index of the instruction being fetched
  index_t readIdx;
  // Table index of the instruction in Memory
  index_t writeIdx;
  logic   writeEn;

  // Counter value riding along with the instruction
  bpDir_t bpDirD;
  bpDir_t bpDirE;
  bpDir_t bpDirM;
  // Counter after training with the Execute outcome
  bpDir_t bpDirNextE;

  // Hash needs PC bits up to indexBits+1 and at least one plain index bit
  if (indexBits < 2 || xlen <= indexBits + 1) begin : gBadParams
    $error("twoBitPredictor needs indexBits >= 2 and xlen > indexBits + 1");
  end

  //////////////////////////////////////////////////
  // PC hash
  //////////////////////////////////////////////////

  // Word index from bit 2 upward
  // Bit 1 only toggles for compressed code, so it folds into the top index bit
  function automatic index_t hashPc(input pc_t pc);
    return {pc[indexBits+1] ^ pc[1], pc[indexBits:2]};
  endfunction

  assign readIdx  = hashPc(pcNextF);
  assign writeIdx = hashPc(pcM);

  // Train only resolved branches that really retire
  assign writeEn = branchM & ~ctrl.stallW & ~ctrl.flushW;

  //////////////////////////////////////////////////
  // Counter table
  //////////////////////////////////////////////////

  // Read register doubles as the Fetch stage register
  bhtRam #(
    .addrBits (indexBits)
  ) bht (
    .clk       (clk),
    .arstN     (arstN),
    .readEn    (~ctrl.stallF),
    .readAddr  (readIdx),
    .readData  (bpDirF),
    .writeEn   (writeEn),
    .writeAddr (writeIdx),
    .writeData (bpDirM)
  );

  //////////////////////////////////////////////////
  // Stage registers
  //////////////////////////////////////////////////

  // Shared next-state rule for the D, E and M registers
  // Stall holds, flush clears, otherwise load from the stage before
  function automatic bpDir_t stageNext(
    input bpDir_t cur,
    input bpDir_t in,
    input logic   stall,
    input logic   flush
  );
    bpDir_t nextVal;
    if (stall) begin
      nextVal = cur;
    end else if (flush) begin
      nextVal = strongNotTaken;
    end else begin
      nextVal = in;
    end
    return nextVal;
  endfunction

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      bpDirD <= strongNotTaken;
      bpDirE <= strongNotTaken;
      bpDirM <= strongNotTaken;
    end else begin
      bpDirD <= stageNext(bpDirD, bpDirF, ctrl.stallD, ctrl.flushD);
      bpDirE <= stageNext(bpDirE, bpDirD, ctrl.stallE, ctrl.flushE);
      // Memory holds the already trained counter
      bpDirM <= stageNext(bpDirM, bpDirNextE, ctrl.stallM, ctrl.flushM);
    end
  end

  //////////////////////////////////////////////////
  // Execute resolution
  //////////////////////////////////////////////////

  // Wrong direction only counts for real branches
  assign bpDirWrongE = branchE & (pcSrcE != predTaken(bpDirE));

  // Step toward the outcome, saturating at both ends
  assign bpDirNextE = satUpdate(bpDirE, pcSrcE);

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Non-branches never flag a misprediction
  noWrongWithoutBranch: assert property (
    @(posedge clk) disable iff (!arstN)
    !branchE |-> !bpDirWrongE
  ) else $error("bpDirWrongE high without branchE");

  // Stalled Fetch keeps the table output steady into the next cycle
  fetchHold: assert property (
    @(posedge clk) disable iff (!arstN)
    ctrl.stallF |=> $stable(bpDirF)
  ) else $error("bpDirF changed while stallF was high");

endmodule

`default_nettype wire

//--- hdl/bpDirTop.sv
// Direction predictor top level, plain pipeline ports onto the stall/flush bundle
`timescale 1ns/1ns
`default_nettype none

module bpDirTop import bpPkg::*; #(
  parameter int xlen      = DEF_XLEN,
  parameter int indexBits = DEF_INDEX_BITS
) (
  input  wire logic            clk,
  input  wire logic            arstN,
  // Stage holds from the hazard unit
  input  wire logic            stallF,
  input  wire logic            stallD,
  input  wire logic            stallE,
  input  wire logic            stallM,
  input  wire logic            stallW,
  // Stage clears from the hazard unit
  input  wire logic            flushD,
  input  wire logic            flushE,
  input  wire logic            flushM,
  input  wire logic            flushW,
  // Fetch and Memory addresses
  input  wire logic [xlen-1:0] pcNextF,
  input  wire logic [xlen-1:0] pcM,
  // Branch markers and resolved direction
  input  wire logic            branchE,
  input  wire logic            branchM,
  input  wire logic            pcSrcE,
  // Counter read for the fetched instruction
  output      logic [1:0]      bpDirF,
  output      logic            bpDirWrongE
);

  //////////////////////////////////////////////////
  // Stall and flush bundle
  //////////////////////////////////////////////////

  // Top level plays the hazard unit side of the bundle
  pipeCtrlIf ctrlBus ();

  assign ctrlBus.stallF = stallF;
  assign ctrlBus.stallD = stallD;
  assign ctrlBus.stallE = stallE;
  assign ctrlBus.stallM = stallM;
  assign ctrlBus.stallW = stallW;
  assign ctrlBus.flushD = flushD;
  assign ctrlBus.flushE = flushE;
  assign ctrlBus.flushM = flushM;
  assign ctrlBus.flushW = flushW;

  //////////////////////////////////////////////////
  // Predictor
  //////////////////////////////////////////////////

  // Counter as seen by the predictor, exported as a raw vector
  bpDir_t bpDirFPred;

  twoBitPredictor #(
    .xlen      (xlen),
    .indexBits (indexBits)
  ) predictor (
    .clk         (clk),
    .arstN       (arstN),
    .ctrl        (ctrlBus.pred),
    .pcNextF     (pcNextF),
    .pcM         (pcM),
    .branchE     (branchE),
    .branchM     (branchM),
    .pcSrcE      (pcSrcE),
    .bpDirF      (bpDirFPred),
    .bpDirWrongE (bpDirWrongE)
  );

  assign bpDirF = bpDirFPred;

endmodule

`default_nettype wire

//--- verification/bpDirModel.svh
// Reference model of the direction predictor with shadow table and per-stage records
`ifndef BP_DIR_MODEL_SVH
`define BP_DIR_MODEL_SVH

// Shadow counters are trusted only where the written flag is set
logic [1:0] shadowTable [0:tableDepth-1];
bit         written     [0:tableDepth-1];

// Counter held by each stage register
logic [1:0] fCnt;
logic [1:0] dCnt;
logic [1:0] eCnt;
logic [1:0] mCnt;
// Set when the model knows the stage counter exactly
bit         fOk;
bit         dOk;
bit         eOk;
bit         mOk;

// Instruction carried by each stage
logic [xlen-1:0] fPc;
logic [xlen-1:0] dPc;
logic [xlen-1:0] ePc;
logic [xlen-1:0] mPc;
bit              fBr;
bit              dBr;
bit              eBr;
bit              mBr;
bit              fTaken;
bit              dTaken;
bit              eTaken;

// Word index from bit 2 up
// Bit 1 flips the top index bit
function automatic int unsigned tableIndex(input logic [xlen-1:0] pc);
  int unsigned idx;
  idx = (pc >> 2) & (tableDepth - 1);
  if (pc[1]) begin
    idx = idx ^ (tableDepth / 2);
  end
  return idx;
endfunction

// Counter counts up on taken and down on not taken
// Clamped to 0..3
function automatic logic [1:0] trainCounter(input logic [1:0] cnt, input bit taken);
  logic [1:0] nextCnt;
  if (taken) begin
    nextCnt = (cnt == 2'd3) ? 2'd3 : cnt + 2'd1;
  end else begin
    nextCnt = (cnt == 2'd0) ? 2'd0 : cnt - 2'd1;
  end
  return nextCnt;
endfunction

// Reset state has every stage strongly not taken and no entry known
task automatic clearModel();
  for (int i = 0; i < tableDepth; i++) begin
    written[i] = 1'b0;
  end
  {fCnt, dCnt, eCnt, mCnt} = '0;
  {fOk, dOk, eOk, mOk} = 4'b1111;
  {fPc, dPc, ePc, mPc} = '0;
  {fBr, dBr, eBr, mBr, fTaken, dTaken, eTaken} = '0;
endtask

// One rising edge of the model pipeline
task automatic stepModel();
  int unsigned rdIdx;
  int unsigned wrIdx;
  logic [1:0]  readCnt;
  bit          readOk;
  // Read sees the table as it was before this edge's write
  rdIdx = tableIndex(pcNextF);
  readCnt = shadowTable[rdIdx];
  readOk = written[rdIdx];
  // Retiring branch trains its entry
  if (mBr && !stallW && !flushW) begin
    wrIdx = tableIndex(mPc);
    shadowTable[wrIdx] = mCnt;
    written[wrIdx] = mOk;
  end
  // Later stages first so each one takes the old value of the stage before
  if (!stallM) begin
    mCnt = flushM ? 2'd0 : trainCounter(eCnt, eTaken);
    mOk = flushM || eOk;
    mPc = ePc;
    mBr = eBr;
  end
  if (!stallE) begin
    eCnt = flushE ? 2'd0 : dCnt;
    eOk = flushE || dOk;
    ePc = dPc;
    eBr = dBr;
    eTaken = dTaken;
  end
  if (!stallD) begin
    dCnt = flushD ? 2'd0 : fCnt;
    dOk = flushD || fOk;
    dPc = fPc;
    dBr = fBr;
    dTaken = fTaken;
  end
  if (!stallF) begin
    fCnt = readCnt;
    fOk = readOk;
    fPc = pcNextF;
    fBr = fetchBr;
    fTaken = fetchTaken;
  end
endtask

`endif

//--- verification/tbBpDir.sv
// Testbench for the branch direction predictor under random pipeline traffic
`timescale 1ns/1ns
`default_nettype none

module tbBpDir import bpPkg::*; ();

  localparam int xlen = DEF_XLEN;
  // Small table so aliasing and saturation show up often
  localparam int idxBits = 4;
  localparam int tableDepth = 2 ** idxBits;
  localparam int clkPeriod = 10;
  localparam int resetCycles = 16;
  localparam int numCycles = 4000;
  // Whole run plus 20 percent
  localparam int watchdogNs = (resetCycles + numCycles) * clkPeriod * 6 / 5;

  logic            clk;
  logic            arstN;
  logic            stallF;
  logic            stallD;
  logic            stallE;
  logic            stallM;
  logic            stallW;
  logic            flushD;
  logic            flushE;
  logic            flushM;
  logic            flushW;
  logic [xlen-1:0] pcNextF;
  logic [xlen-1:0] pcM;
  logic            branchE;
  logic            branchM;
  logic            pcSrcE;
  logic [1:0]      bpDirF;
  logic            bpDirWrongE;

  // Branch flag and outcome of the instruction being fetched
  bit              fetchBr;
  bit              fetchTaken;
  logic [31:0]     rngState = 32'd31;
  logic [xlen-1:0] pcPool [0:11];
  // Error tallies per check
  int              wrongErrs;
  int              tableErrs;
  int              holdErrs;
  int              otherErrs;
  // Fetches that hit an entry the model has seen written
  int              knownReads;
  logic [1:0]      prevBpDirF;
  logic            expWrongE;

  `include "bpDirModel.svh"

  bpDirTop #(
    .xlen      (xlen),
    .indexBits (idxBits)
  ) UUT (
    .clk         (clk),
    .arstN       (arstN),
    .stallF      (stallF),
    .stallD      (stallD),
    .stallE      (stallE),
    .stallM      (stallM),
    .stallW      (stallW),
    .flushD      (flushD),
    .flushE      (flushE),
    .flushM      (flushM),
    .flushW      (flushW),
    .pcNextF     (pcNextF),
    .pcM         (pcM),
    .branchE     (branchE),
    .branchM     (branchM),
    .pcSrcE      (pcSrcE),
    .bpDirF      (bpDirF),
    .bpDirWrongE (bpDirWrongE)
  );

  //////////////////////////////////////////////////
  // Clock, random source, stimulus
  //////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // 32-bit xorshift
  function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  function automatic bit rollPercent(input int unsigned pct);
    return (nextRand() % 100) < pct;
  endfunction

  // New fetch plus the controls for every stage
  task automatic driveInputs();
    int unsigned pick;
    stallF = rollPercent(15);
    stallD = rollPercent(15);
    stallE = rollPercent(15);
    stallM = rollPercent(15);
    stallW = rollPercent(15);
    flushD = rollPercent(15);
    flushE = rollPercent(15);
    flushM = rollPercent(15);
    flushW = rollPercent(15);
    pick = nextRand() % 12;
    pcNextF = pcPool[pick];
    fetchBr = rollPercent(70);
    // First half of the pool leans taken
    // Second half leans not taken
    fetchTaken = rollPercent((pick < 6) ? 85 : 15);
    // Execute and Memory inputs follow the model's records
    branchE = eBr;
    pcSrcE = eTaken;
    branchM = mBr;
    pcM = mPc;
  endtask

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Expected flag from the model's Execute counter
  assign expWrongE = branchE & (pcSrcE != eCnt[1]);

  // bpDirF one edge earlier
  always_ff @(posedge clk) begin
    prevBpDirF <= bpDirF;
  end

  wrongCheck: assert property (
    @(posedge clk) disable iff (!arstN) eOk |-> bpDirWrongE == expWrongE
  ) else begin
    wrongErrs++;
    $display("FAILED t=%0t bpDirWrongE expected %b got %b", $time,
      $sampled(expWrongE), $sampled(bpDirWrongE));
  end

  // Only counters the model knows are compared
  // Unwritten entries hold power-up contents
  tableCheck: assert property (
    @(posedge clk) disable iff (!arstN) fOk |-> bpDirF == fCnt
  ) else begin
    tableErrs++;
    $display("FAILED t=%0t bpDirF expected %b got %b", $time,
      $sampled(fCnt), $sampled(bpDirF));
  end

  holdCheck: assert property (
    @(posedge clk) disable iff (!arstN) stallF |=> bpDirF == prevBpDirF
  ) else begin
    holdErrs++;
    $display("FAILED t=%0t bpDirF expected %b got %b", $time,
      $sampled(prevBpDirF), $sampled(bpDirF));
  end

  //////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////

  initial begin
    #(watchdogNs);
    $display("Watchdog expired before the test sequence finished");
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    // Pairs that differ only in bit 1 plus entries that alias
    pcPool = '{32'h0000_1000, 32'h0000_1002, 32'h0000_1004, 32'h0000_1006,
               32'h0000_1022, 32'h0000_1040, 32'h0000_2008, 32'h0000_200a,
               32'h0000_1024, 32'h0000_1038, 32'h0000_301c, 32'h0000_3036};
    {wrongErrs, tableErrs, holdErrs, otherErrs, knownReads} = '0;
    arstN = 1'b0;
    {stallF, stallD, stallE, stallM, stallW} = '0;
    {flushD, flushE, flushM, flushW} = '0;
    {branchE, branchM, pcSrcE} = '0;
    pcNextF = '0;
    pcM = '0;
    fetchBr = 1'b0;
    fetchTaken = 1'b0;
    clearModel();
    repeat (resetCycles) @(posedge clk);
    #1;
    arstN = 1'b1;
    driveInputs();
    repeat (numCycles) begin
      @(posedge clk);
      // Loading fetch that reads an entry already written
      if (!stallF && written[tableIndex(pcNextF)]) begin
        knownReads++;
      end
      stepModel();
      #1;
      driveInputs();
    end
    @(posedge clk);
    #1;
    if (knownReads == 0) begin
      $display("No fetch ever read a table entry that had been written");
      otherErrs++;
    end
    $display("Errors: bpDirWrongE %0d, bpDirF table %0d, bpDirF hold %0d, other %0d",
      wrongErrs, tableErrs, holdErrs, otherErrs);
    if (wrongErrs + tableErrs + holdErrs + otherErrs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+verification
hdl/bpPkg.sv
hdl/pipeCtrlIf.sv
hdl/bhtRam.sv
hdl/twoBitPredictor.sv
hdl/bpDirTop.sv
verification/tbBpDir.sv

//--- Bender.yml
package:
  name: bpDir

sources:
  # Package first, then the interface and the RTL bottom up
  - hdl/bpPkg.sv
  - hdl/pipeCtrlIf.sv
  - hdl/bhtRam.sv
  - hdl/twoBitPredictor.sv
  - hdl/bpDirTop.sv

  # Testbench with its model header
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/tbBpDir.sv
